// File: vlog.f
+incdir+include
hdl/raw10_pkg.sv
hdl/raw10_gearbox.sv
hdl/raw10_unpacker.sv
hdl/raw10_csr.sv
hdl/raw10_rx_top.sv
dv/raw10_clkgen.sv
dv/raw10_checker.sv
dv/raw10_tb.sv

// File: dv/raw10_tb.sv
`include "raw10_macros.svh"

module raw10_tb;

  localparam int RAND_LINES     = 12; // lengths cycle through 5, 10 and 15 words.
  localparam int RAND_WORDS     = RAND_LINES / 3 * 30;
  localparam int BLACK_WORDS    = 25;
  localparam int TOTAL_WORDS    = 5 + RAND_WORDS + BLACK_WORDS + 10;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 1000;
  localparam int OFF_CYCLES     = 20;

  logic                      clk_i;
  logic                      rst_i;
  raw10_pkg::axil_req_t      axil_req;
  raw10_pkg::axil_rsp_t      axil_rsp;
  raw10_pkg::in_beat_t       in_beat;
  logic                      in_valid;
  logic                      in_ready;
  raw10_pkg::pix_beat_t      pix;
  logic                      pix_valid;
  logic                      pix_ready;
  logic [31:0]               rng_state = 32'h6072db20;
  logic [31:0]               stall_rnd;
  logic                      stalls_on = 1'b0;
  logic [7:0]                sent_bytes [0:TOTAL_WORDS*4-1];
  logic                      byte_last [0:TOTAL_WORDS*4-1];
  int                        byte_count = 0;
  int                        lines_sent = 0;
  int                        lines_at_clear = 0;
  int                        tb_errors = 0;
  int                        i;
  logic [31:0]               line_words [0:15];
  logic [31:0]               directed_words [0:4];
  logic [`RAW10_BLACK_W-1:0] black_level = '0;

  raw10_clkgen raw10_clkgen_i (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  raw10_rx_top raw10_rx_top_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .axil_i      (axil_req),
    .axil_o      (axil_rsp),
    .in_i        (in_beat),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .pix_o       (pix),
    .pix_valid_o (pix_valid),
    .pix_ready_i (pix_ready)
  );

  raw10_checker raw10_checker_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pix_i       (pix),
    .pix_valid_i (pix_valid),
    .pix_ready_i (pix_ready)
  );

  function logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // fills line_words and logs the bytes low byte first.
  task automatic record_line(input int words, input bit directed);
    logic [31:0] data;
    int          w;
    int          b;
    for (w = 0; w < words; w++)
    begin
      data = directed ? directed_words[w] : next_random();
      line_words[w] = data;
      for (b = 0; b < 4; b++)
      begin
        sent_bytes[byte_count] = data[8*b +: 8];
        byte_last[byte_count]  = w == words - 1 && b == 3;
        byte_count++;
      end
    end
    lines_sent++;
  endtask

  task automatic drive_line(input int words, input bit gaps);
    logic [31:0] r;
    int          w;
    for (w = 0; w < words; w++)
    begin
      r = next_random();
      while (gaps && r[31:30] == 2'b00)
      begin
        in_valid = 1'b0;
        @(negedge clk_i);
        r = next_random();
      end
      in_beat.data = line_words[w];
      in_beat.last = w == words - 1;
      in_valid     = 1'b1;
      do
        @(posedge clk_i);
      while (!in_ready);
      @(negedge clk_i);
    end
    in_valid = 1'b0;
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.bready  = 1'b1;
    do
      @(posedge clk_i);
    while (!axil_rsp.awready);
    if (axil_rsp.wready !== 1'b1)
    begin
      $display("** Error at %0t: write to 0x%02h got awready without wready",
               $time, addr);
      tb_errors++;
    end
    @(negedge clk_i);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    do
      @(posedge clk_i);
    while (!axil_rsp.bvalid);
    if (axil_rsp.bresp != `RAW10_RESP_OKAY)
    begin
      $display("** Error at %0t: write to 0x%02h got a response other than OKAY",
               $time, addr);
      tb_errors++;
    end
    @(negedge clk_i);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    do
      @(posedge clk_i);
    while (!axil_rsp.arready);
    @(negedge clk_i);
    axil_req.arvalid = 1'b0;
    do
      @(posedge clk_i);
    while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    if (axil_rsp.rresp != `RAW10_RESP_OKAY)
    begin
      $display("** Error at %0t: read from 0x%02h got a response other than OKAY",
               $time, addr);
      tb_errors++;
    end
    @(negedge clk_i);
    axil_req.rready = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    axil_read(addr, data);
    if (data !== expected)
    begin
      $display("** Error at %0t: register 0x%02h reads 0x%08h, expected 0x%08h",
               $time, addr, data, expected);
      tb_errors++;
    end
  endtask

  task automatic set_black(input logic [`RAW10_BLACK_W-1:0] level);
    axil_write(`RAW10_REG_BLACK, 32'(level));
    black_level = level;
  endtask

  task automatic wait_drain();
    while (raw10_checker_i.pix_count < byte_count / 5 * 4)
      @(negedge clk_i);
    repeat (4) @(negedge clk_i);
  endtask

  task automatic report_counts();
    $display("pixel errors: %0d, register and stream errors: %0d",
             raw10_checker_i.errors, tb_errors);
  endtask

  always @(negedge clk_i)
    if (stalls_on)
    begin
      stall_rnd = next_random();
      pix_ready = stall_rnd[31:30] != 2'b00; // about one stall in four.
    end
    else
      pix_ready = 1'b1;

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout: the stream did not finish within %0d cycles", TIMEOUT_CYCLES);
    report_counts();
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    axil_req  = '0;
    in_beat   = '0;
    in_valid  = 1'b0;
    pix_ready = 1'b1;
    // with black at 0x155 most pixels of the first three groups clamp to zero.
    directed_words[0] = 32'hff551000;
    directed_words[1] = 32'h565554e4;
    directed_words[2] = 32'h3020c601;
    directed_words[3] = 32'h601b5040;
    directed_words[4] = 32'ha0908070;
    @(negedge rst_i);
    @(negedge clk_i);

    axil_write(`RAW10_REG_CTRL, 32'h1);
    check_reg(`RAW10_REG_CTRL, 32'h1);
    record_line(5, 1'b0);
    drive_line(5, 1'b0);
    wait_drain();
    if (raw10_checker_i.lines_seen != 1 || raw10_checker_i.pix_count != 16)
    begin
      $display("** Error at %0t: first line gave %0d pixels and %0d line ends",
               $time, raw10_checker_i.pix_count, raw10_checker_i.lines_seen);
      tb_errors++;
    end

    stalls_on = 1'b1;
    for (i = 0; i < RAND_LINES; i++)
    begin
      record_line(5 * (1 + i % 3), 1'b0);
      drive_line(5 * (1 + i % 3), 1'b1);
    end
    wait_drain();

    set_black(10'h155);
    check_reg(`RAW10_REG_BLACK, 32'h155);
    record_line(5, 1'b1);
    drive_line(5, 1'b1);
    for (i = 0; i < (BLACK_WORDS - 5) / 5; i++)
    begin
      record_line(5, 1'b0);
      drive_line(5, 1'b1);
    end
    wait_drain();

    check_reg(`RAW10_REG_LINES, lines_sent);
    axil_write(`RAW10_REG_LINES, 32'h0);
    lines_at_clear = lines_sent;
    check_reg(`RAW10_REG_LINES, 32'h0);
    check_reg(8'h0c, 32'h0);

    // enable clear must hold the input off.
    stalls_on = 1'b0;
    axil_write(`RAW10_REG_CTRL, 32'h0);
    check_reg(`RAW10_REG_CTRL, 32'h0);
    record_line(10, 1'b0);
    in_beat.data = line_words[0];
    in_beat.last = 1'b0;
    in_valid     = 1'b1;
    repeat (OFF_CYCLES)
    begin
      @(posedge clk_i);
      if (in_ready || pix_valid)
      begin
        $display("** Error at %0t: stream moved while enable is clear", $time);
        tb_errors++;
      end
      @(negedge clk_i);
    end
    in_valid = 1'b0;
    axil_write(`RAW10_REG_CTRL, 32'h1);
    drive_line(10, 1'b1);
    wait_drain();
    check_reg(`RAW10_REG_LINES, lines_sent - lines_at_clear);
    if (raw10_checker_i.lines_seen != lines_sent)
    begin
      $display("** Error at %0t: %0d line ends seen, expected %0d",
               $time, raw10_checker_i.lines_seen, lines_sent);
      tb_errors++;
    end

    report_counts();
    if (raw10_checker_i.errors + tb_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: dv/raw10_checker.sv
`include "raw10_macros.svh"

module raw10_checker (
  input logic                 clk_i,
  input logic                 rst_i,
  input raw10_pkg::pix_beat_t pix_i,
  input logic                 pix_valid_i,
  input logic                 pix_ready_i
);

  int                      pix_count  = 0;
  int                      lines_seen = 0;
  int                      errors     = 0;
  int                      base;
  int                      pix_k;
  logic [`RAW10_PIX_W-1:0] exp_pix;
  logic                    exp_last;

  // msb byte times four plus the two lsb bits of this pixel, less black, floored at zero.
  function automatic logic [`RAW10_PIX_W-1:0] expected_pixel(
    input logic [7:0] msb,
    input logic [7:0] lsb_byte,
    input int         idx,
    input int         black
  );
    int value;
    value = msb * 4 + ((lsb_byte >> (2 * idx)) & 3);
    value = value - black;
    if (value < 0)
      value = 0;
    return value[`RAW10_PIX_W-1:0];
  endfunction

  always @(posedge clk_i)
    if (!rst_i && pix_valid_i && pix_ready_i)
    begin
      base  = pix_count / 4 * 5; // five bytes per group.
      pix_k = pix_count % 4;
      if (base + 4 >= raw10_tb.byte_count)
      begin
        $display("pixel %0d came out at time %0t with no input bytes behind it",
                 pix_count, $time);
        errors++;
      end
      else
      begin
        exp_pix  = expected_pixel(raw10_tb.sent_bytes[base + pix_k],
                                  raw10_tb.sent_bytes[base + 4], pix_k,
                                  raw10_tb.black_level);
        exp_last = pix_k == 3 && raw10_tb.byte_last[base + 4];
        if (pix_i.pix !== exp_pix || pix_i.last !== exp_last)
        begin
          $display("** Error at %0t: pixel %0d is 0x%03h last %0b, expected 0x%03h last %0b",
                   $time, pix_count, pix_i.pix, pix_i.last, exp_pix, exp_last);
          errors++;
        end
      end
      if (pix_i.last)
        lines_seen++;
      pix_count++;
    end

endmodule

// File: dv/raw10_clkgen.sv
module raw10_clkgen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(negedge clk_o);
    rst_o = 1'b0; // released on a falling edge.
  end

  always #(PERIOD/2) clk_o = ~clk_o;

endmodule

// File: hdl/raw10_rx_top.sv
module raw10_rx_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  raw10_pkg::axil_req_t axil_i,
  output raw10_pkg::axil_rsp_t axil_o,
  input  raw10_pkg::in_beat_t  in_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output raw10_pkg::pix_beat_t pix_o,
  output logic                 pix_valid_o,
  input  logic                 pix_ready_i
);

  raw10_pkg::cfg_t      cfg;
  raw10_pkg::grp_beat_t grp;
  logic                 grp_valid;
  logic                 grp_ready;
  logic                 line_done;

  raw10_csr raw10_csr_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .axil_i      (axil_i),
    .axil_o      (axil_o),
    .cfg_o       (cfg),
    .line_done_i (line_done)
  );

  raw10_gearbox raw10_gearbox_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_i        (in_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_o       (grp),
    .out_valid_o (grp_valid),
    .out_ready_i (grp_ready)
  );

  raw10_unpacker raw10_unpacker_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_i       (cfg),
    .in_i        (grp),
    .in_valid_i  (grp_valid),
    .in_ready_o  (grp_ready),
    .pix_o       (pix_o),
    .pix_valid_o (pix_valid_o),
    .pix_ready_i (pix_ready_i),
    .line_done_o (line_done)
  );

endmodule

// File: hdl/raw10_csr.sv
`include "raw10_macros.svh"

module raw10_csr (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  raw10_pkg::axil_req_t axil_i,
  output raw10_pkg::axil_rsp_t axil_o,
  output raw10_pkg::cfg_t      cfg_o,
  input  logic                 line_done_i
);

  logic                      awready_q;
  logic                      bvalid_q;
  logic                      arready_q;
  logic                      rvalid_q;
  logic                      wr_go;
  logic                      rd_go;
  logic                      wr_ctrl;
  logic                      wr_black;
  logic                      wr_lines;
  logic                      en_q;
  logic [`RAW10_BLACK_W-1:0] black_q;
  logic [`RAW10_AXIL_DW-1:0] lines_q;
  logic [`RAW10_AXIL_DW-1:0] rdata_d;
  logic [`RAW10_AXIL_DW-1:0] rdata_q;

  assign wr_go = axil_i.awvalid && axil_i.wvalid && !awready_q && !bvalid_q;
  assign rd_go = axil_i.arvalid && !arready_q && !rvalid_q;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      awready_q <= 1'b0;
      arready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      awready_q <= wr_go; // one-cycle pulse.
      arready_q <= rd_go;
      if (awready_q)
        bvalid_q <= 1'b1;
      else if (axil_i.bready)
        bvalid_q <= 1'b0;
      if (arready_q)
        rvalid_q <= 1'b1;
      else if (axil_i.rready)
        rvalid_q <= 1'b0;
    end

  assign wr_ctrl  = awready_q && axil_i.awaddr == `RAW10_REG_CTRL;
  assign wr_black = awready_q && axil_i.awaddr == `RAW10_REG_BLACK;
  assign wr_lines = awready_q && axil_i.awaddr == `RAW10_REG_LINES;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      en_q    <= 1'b0;
      black_q <= '0;
      lines_q <= '0;
    end
    else
    begin
      if (wr_ctrl && axil_i.wstrb[0])
        en_q <= axil_i.wdata[0];
      if (wr_black && axil_i.wstrb[0])
        black_q[7:0] <= axil_i.wdata[7:0];
      if (wr_black && axil_i.wstrb[1])
        black_q[`RAW10_BLACK_W-1:8] <= axil_i.wdata[`RAW10_BLACK_W-1:8];
      if (wr_lines)
        lines_q <= '0; // clear wins over a line end.
      else if (line_done_i)
        lines_q <= lines_q + 1'b1;
    end

  always_comb
  begin
    case (axil_i.araddr)
      `RAW10_REG_CTRL:  rdata_d = {{(`RAW10_AXIL_DW-1){1'b0}}, en_q};
      `RAW10_REG_BLACK: rdata_d = {{(`RAW10_AXIL_DW-`RAW10_BLACK_W){1'b0}}, black_q};
      `RAW10_REG_LINES: rdata_d = lines_q;
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i)
    if (arready_q)
      rdata_q <= rdata_d;

  assign axil_o.awready = awready_q;
  assign axil_o.wready  = awready_q;
  assign axil_o.bvalid  = bvalid_q;
  assign axil_o.bresp   = `RAW10_RESP_OKAY;
  assign axil_o.arready = arready_q;
  assign axil_o.rvalid  = rvalid_q;
  assign axil_o.rdata   = rdata_q;
  assign axil_o.rresp   = `RAW10_RESP_OKAY;

  assign cfg_o.en    = en_q;
  assign cfg_o.black = black_q;

  a_one_write: assert property (@(posedge clk_i) disable iff (rst_i)
    axil_o.awready |-> !axil_o.bvalid ##1 axil_o.bvalid);

endmodule

// File: hdl/raw10_unpacker.sv
`include "raw10_macros.svh"

module raw10_unpacker (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  raw10_pkg::cfg_t      cfg_i,
  input  raw10_pkg::grp_beat_t in_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output raw10_pkg::pix_beat_t pix_o,
  output logic                 pix_valid_o,
  input  logic                 pix_ready_i,
  output logic                 line_done_o
);

  raw10_pkg::grp_u         grp_q;
  logic                    last_q;
  logic                    full_q;
  logic [1:0]              idx_q;
  logic                    send;
  logic                    send_end;
  logic                    take;
  logic [7:0]              msb;
  logic [1:0]              lsb;
  logic [`RAW10_PIX_W-1:0] raw;
  logic [`RAW10_PIX_W:0]   diff;

  assign send       = full_q && pix_ready_i;
  assign send_end   = send && idx_q == 2'd3;
  assign in_ready_o = cfg_i.en && (!full_q || send_end); // reload behind pixel 3.
  assign take       = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      full_q <= 1'b0;
      idx_q  <= 2'd0;
    end
    else if (take)
    begin
      full_q <= 1'b1;
      idx_q  <= 2'd0;
    end
    else if (send)
    begin
      if (idx_q == 2'd3)
        full_q <= 1'b0;
      idx_q <= idx_q + 2'd1;
    end

  always_ff @(posedge clk_i)
    if (take)
    begin
      grp_q  <= in_i.grp;
      last_q <= in_i.last;
    end

  assign msb  = grp_q.raw.msb[idx_q];
  assign lsb  = grp_q.raw.lsb[{idx_q, 1'b0} +: 2];
  assign raw  = {msb, lsb};
  assign diff = {1'b0, raw} - {1'b0, cfg_i.black}; // top bit set means below black.

  assign pix_o.pix   = diff[`RAW10_PIX_W] ? '0 : diff[`RAW10_PIX_W-1:0];
  assign pix_o.last  = last_q && idx_q == 2'd3;
  assign pix_valid_o = full_q;
  assign line_done_o = send && pix_o.last;

  // a group taken with last ends the line on its fourth pixel transfer.
  a_line_done: assert property (@(posedge clk_i) disable iff (rst_i)
    take && in_i.last |=> (pix_valid_o && pix_ready_i)[->4] ##0 line_done_o);

endmodule

// File: hdl/raw10_gearbox.sv
module raw10_gearbox (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  raw10_pkg::in_beat_t  in_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output raw10_pkg::grp_beat_t out_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  typedef enum logic [2:0] {
    W0_S,
    W1_S,
    W2_S,
    W3_S,
    W4_S
  } state_t;

  state_t           state_q;
  state_t           state_d;
  logic [3:0][7:0]  cur;
  logic [3:0][7:0]  prev_q;
  raw10_pkg::grp_u  grp_q;
  logic             last_q;
  logic             acc;

  assign in_ready_o = out_ready_i;
  assign acc        = in_valid_i && in_ready_o;
  assign cur        = in_i.data;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      state_q <= W0_S;
    else
      state_q <= state_d;

  always_comb
  begin
    state_d = state_q;
    if (acc)
    begin
      case (state_q)
        W0_S: state_d = W1_S;
        W1_S: state_d = in_i.last ? W0_S : W2_S; // short line restarts.
        W2_S: state_d = in_i.last ? W0_S : W3_S;
        W3_S: state_d = in_i.last ? W0_S : W4_S;
        W4_S: state_d = W0_S;
        default: state_d = W0_S;
      endcase
    end
  end

  always_ff @(posedge clk_i)
    if (acc)
      prev_q <= cur;

  // five words carry four groups, one per word after the first.
  always_ff @(posedge clk_i)
    if (acc)
    begin
      last_q <= in_i.last;
      case (state_q)
        W0_S: grp_q.bytes[3:0] <= cur;
        W1_S: grp_q.bytes[4]   <= cur[0];
        W2_S: grp_q.bytes      <= {cur[1:0], prev_q[3:1]};
        W3_S: grp_q.bytes      <= {cur[2:0], prev_q[3:2]};
        W4_S: grp_q.bytes      <= {cur, prev_q[3]};
        default: grp_q.bytes   <= grp_q.bytes;
      endcase
    end

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      out_valid_o <= 1'b0;
    else if (acc && state_q != W0_S)
      out_valid_o <= 1'b1;
    else if (out_ready_i)
      out_valid_o <= 1'b0;

  assign out_o.grp  = grp_q;
  assign out_o.last = last_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

// File: hdl/raw10_pkg.sv
`include "raw10_macros.svh"

package raw10_pkg;

  typedef struct packed {
    logic [`RAW10_IN_W-1:0] data;
    logic                   last;
  } in_beat_t;

  // byte view for the gearbox, pixel view for the unpacker.
  typedef union packed {
    logic [`RAW10_GRP_W/8-1:0][7:0] bytes;
    struct packed {
      logic [7:0]                     lsb; // pixel k in bits 2k+1:2k.
      logic [`RAW10_GRP_W/8-2:0][7:0] msb;
    } raw;
  } grp_u;

  typedef struct packed {
    grp_u grp;
    logic last;
  } grp_beat_t;

  typedef struct packed {
    logic [`RAW10_PIX_W-1:0] pix;
    logic                    last;
  } pix_beat_t;

  typedef struct packed {
    logic                      en;
    logic [`RAW10_BLACK_W-1:0] black;
  } cfg_t;

  typedef struct packed {
    logic                      awvalid;
    logic [`RAW10_AXIL_AW-1:0] awaddr;
    logic                      wvalid;
    logic [`RAW10_AXIL_DW-1:0] wdata;
    logic [`RAW10_AXIL_DW/8-1:0] wstrb;
    logic                      bready;
    logic                      arvalid;
    logic [`RAW10_AXIL_AW-1:0] araddr;
    logic                      rready;
  } axil_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [`RAW10_AXIL_DW-1:0] rdata;
    logic [1:0]                rresp;
  } axil_rsp_t;

endpackage

// File: include/raw10_macros.svh
`ifndef RAW10_MACROS_SVH
`define RAW10_MACROS_SVH

`define RAW10_IN_W      32
`define RAW10_GRP_W     40
`define RAW10_PIX_W     10
`define RAW10_BLACK_W   10

`define RAW10_AXIL_AW   8
`define RAW10_AXIL_DW   32
`define RAW10_RESP_OKAY 2'b00

`define RAW10_REG_CTRL  8'h00 // bit 0 is enable.
`define RAW10_REG_BLACK 8'h04
`define RAW10_REG_LINES 8'h08 // write clears.

`endif
